// File: hdl/pt_walk_ctrl.sv
// Page walk FSM with depth tracking, index shifting, entry address and fill generation
`timescale 1ns/100ps
`default_nettype none

module pt_walk_ctrl
(
    input  wire logic                                   clk,
    input  wire logic                                   reset,

    // Configuration gate
    input  wire pt_walk_pkg::pt_cfg_t                   cfg,

    // Walk requests
    input  wire pt_walk_pkg::walk_req_t                 req,
    input  wire logic                                   req_valid,
    output logic                                        req_ready,

    // Walk results
    output pt_walk_pkg::tlb_fill_t                      fill,
    output logic                                        fill_valid,
    input  wire logic                                   fill_ready,
    output logic                                        not_present,

    // Entry reads
    output logic                                        rd_start,
    output logic [pt_walk_pkg::WB_ADR_WIDTH-1:0]        rd_adr,
    input  wire logic                                   rsp_valid,
    input  wire pt_walk_pkg::pte_t                      rsp_pte
);

    // ========================================
    // Local types and constants
    // ========================================

    typedef logic [pt_walk_pkg::PT_IDX_WIDTH-1:0] idx_t;
    // Element [PT_LEVELS-1] is the index of the current level
    typedef idx_t [pt_walk_pkg::PT_LEVELS-1:0] idx_vec_t;
    typedef logic [pt_walk_pkg::PT_DEPTH_WIDTH-1:0] depth_t;

    localparam depth_t LAST_DEPTH = depth_t'(pt_walk_pkg::PT_LEVELS - 1);
    localparam depth_t BIG_DEPTH  = depth_t'(pt_walk_pkg::BIG_PAGE_DEPTH);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WALK,
        ST_FILL,
        ST_FAULT
    } state_t;

    state_t state;
    logic   enabled;
    logic   req_accept;

    // Walk context
    logic [pt_walk_pkg::VA_PAGE_WIDTH-1:0] va_page;
    logic [pt_walk_pkg::PA_PAGE_WIDTH-1:0] cur_page;
    idx_vec_t                              idx_vec;
    depth_t                                depth;

    // Response classification
    logic rsp_term;
    logic rsp_error;
    logic term_too_high;
    logic table_too_deep;
    logic walk_fault;

    // ========================================
    // Request side
    // ========================================

    // Only one walk at a time
    assign req_ready  = enabled && (state == ST_IDLE);
    assign req_accept = req_ready && req_valid;

    // ========================================
    // Entry evaluation
    // ========================================

    assign rsp_term  = rsp_pte.status.terminal;
    assign rsp_error = rsp_pte.status.error;

    // Terminal above the 2 MB level is malformed
    assign term_too_high = rsp_term && (depth < BIG_DEPTH);

    // Pointer at the leaf level has nowhere to go
    assign table_too_deep = !rsp_term && (depth == LAST_DEPTH);

    // Missing entries read as all ones, so the error bit covers them too
    assign walk_fault = rsp_error || term_too_high || table_too_deep;

    // ========================================
    // Control FSM
    // ========================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= ST_IDLE;
            enabled  <= 1'b0;
            rd_start <= 1'b0;
        end
        else
        begin
            enabled  <= cfg.enable;
            rd_start <= 1'b0;

            case (state)
                ST_IDLE:
                begin
                    // First read goes out right after acceptance
                    if (req_accept)
                    begin
                        state    <= ST_WALK;
                        rd_start <= 1'b1;
                    end
                end

                ST_WALK:
                begin
                    if (rsp_valid)
                    begin
                        if (walk_fault)
                        begin
                            state <= ST_FAULT;
                        end
                        else if (rsp_term)
                        begin
                            state <= ST_FILL;
                        end
                        else
                        begin
                            // Descend one level
                            rd_start <= 1'b1;
                        end
                    end
                end

                ST_FILL:
                begin
                    // Hold the fill until the TLB takes it
                    if (fill_ready)
                    begin
                        state <= ST_IDLE;
                    end
                end

                default:
                begin
                    // Single not-present cycle then back to idle
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // ========================================
    // Walk datapath
    // ========================================

    always_ff @(posedge clk)
    begin
        if (req_accept)
        begin
            // Start at the root with the top index in front
            va_page  <= req.va_page;
            idx_vec  <= req.va_page;
            depth    <= '0;
            cur_page <= cfg.root;
        end
        else if ((state == ST_WALK) && rsp_valid)
        begin
            // Next table page, or the translated page on a terminal entry
            cur_page <= rsp_pte.page;
            idx_vec  <= {idx_vec[pt_walk_pkg::PT_LEVELS-2:0], idx_t'(0)};

            // Depth stays put on a terminal so it still selects the page size
            if (!rsp_term)
            begin
                depth <= depth + depth_t'(1);
            end
        end
    end

    // Entry address within the current table page
    assign rd_adr = {cur_page, idx_vec[pt_walk_pkg::PT_LEVELS-1]};

    // ========================================
    // Results
    // ========================================

    assign fill_valid  = (state == ST_FILL);
    assign not_present = (state == ST_FAULT);

    always_comb
    begin
        fill.va_page  = va_page;
        fill.pa_page  = cur_page;
        // 2 MB when the walk stopped one level early
        fill.big_page = (depth == BIG_DEPTH);
    end

endmodule

`default_nettype wire

// File: hdl/pt_walk_pkg.sv
// Page table walker package with table geometry, entry field positions and shared structs
`default_nettype none

package pt_walk_pkg;

    // ========================================
    // Table geometry
    // ========================================

    // Each level of the tree indexes 512 entries
    localparam int PT_IDX_WIDTH     = 9;
    localparam int PT_LEVELS        = 4;
    localparam int PT_DEPTH_WIDTH   = 2;

    // 48-bit VA and 40-bit PA with 4 KB pages
    localparam int VA_PAGE_WIDTH    = 36;
    localparam int PA_PAGE_WIDTH    = 28;
    localparam int PAGE_OFFSET_BITS = 12;

    // One 64-bit entry per bus word
    localparam int PTE_WIDTH        = 64;
    // Entry address is the table page followed by the level index
    localparam int WB_ADR_WIDTH     = PA_PAGE_WIDTH + PT_IDX_WIDTH;

    // Terminal entry at this depth maps a 2 MB page
    localparam int BIG_PAGE_DEPTH   = 2;

    // ========================================
    // Entry field positions
    // ========================================

    // Low status bits of an entry
    localparam int PTE_TERMINAL_BIT = 0;
    localparam int PTE_ERROR_BIT    = 1;

    typedef struct packed {
        logic error;
        logic terminal;
    } pte_status_t;

    // Decoded entry
    // Page field sits just above the page offset
    typedef struct packed {
        logic [PA_PAGE_WIDTH-1:0] page;
        pte_status_t              status;
    } pte_t;

    // ========================================
    // Interface structs
    // ========================================

    typedef struct packed {
        logic                     enable;
        logic [PA_PAGE_WIDTH-1:0] root;
    } pt_cfg_t;

    typedef struct packed {
        logic [VA_PAGE_WIDTH-1:0] va_page;
    } walk_req_t;

    typedef struct packed {
        logic [VA_PAGE_WIDTH-1:0] va_page;
        logic [PA_PAGE_WIDTH-1:0] pa_page;
        logic                     big_page;
    } tlb_fill_t;

    // Wishbone classic, read only
    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic [WB_ADR_WIDTH-1:0] adr;
    } wb_master_t;

    typedef struct packed {
        logic                 ack;
        logic [PTE_WIDTH-1:0] dat;
    } wb_slave_t;

endpackage

`default_nettype wire

// File: hdl/pt_walk_top.sv
// Page table walker top level joining the walk FSM and the Wishbone reader
`timescale 1ns/100ps
`default_nettype none

module pt_walk_top
(
    input  wire logic                       clk,
    input  wire logic                       reset,

    // Enable and table root
    input  wire pt_walk_pkg::pt_cfg_t       cfg,

    // Translation requests
    input  wire pt_walk_pkg::walk_req_t     req,
    input  wire logic                       req_valid,
    output logic                            req_ready,

    // Translation fills and failures
    output pt_walk_pkg::tlb_fill_t          fill,
    output logic                            fill_valid,
    input  wire logic                       fill_ready,
    output logic                            not_present,

    // Host memory bus
    output pt_walk_pkg::wb_master_t         wb_m,
    input  wire pt_walk_pkg::wb_slave_t     wb_s
);

    // ========================================
    // FSM to reader handshake
    // ========================================

    logic                                  rd_start;
    logic [pt_walk_pkg::WB_ADR_WIDTH-1:0]  rd_adr;
    logic                                  rsp_valid;
    pt_walk_pkg::pte_t                     rsp_pte;

    // Walk sequencing and result generation
    pt_walk_ctrl pt_walk_ctrl_i
    (
        .clk         (clk),
        .reset       (reset),
        .cfg         (cfg),
        .req         (req),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .fill        (fill),
        .fill_valid  (fill_valid),
        .fill_ready  (fill_ready),
        .not_present (not_present),
        .rd_start    (rd_start),
        .rd_adr      (rd_adr),
        .rsp_valid   (rsp_valid),
        .rsp_pte     (rsp_pte)
    );

    // One entry read at a time
    pt_wb_reader pt_wb_reader_i
    (
        .clk       (clk),
        .reset     (reset),
        .rd_start  (rd_start),
        .rd_adr    (rd_adr),
        .wb_m      (wb_m),
        .wb_s      (wb_s),
        .rsp_valid (rsp_valid),
        .rsp_pte   (rsp_pte)
    );

endmodule

`default_nettype wire

// File: hdl/pt_wb_reader.sv
// Wishbone classic read master with registered, decoded entry response
`timescale 1ns/100ps
`default_nettype none

module pt_wb_reader
(
    input  wire logic                               clk,
    input  wire logic                               reset,

    // Read request from the walk FSM
    input  wire logic                               rd_start,
    input  wire logic [pt_walk_pkg::WB_ADR_WIDTH-1:0] rd_adr,

    // Wishbone bus
    output pt_walk_pkg::wb_master_t                 wb_m,
    input  wire pt_walk_pkg::wb_slave_t             wb_s,

    // Decoded response
    output logic                                    rsp_valid,
    output pt_walk_pkg::pte_t                       rsp_pte
);

    typedef enum logic {
        RD_IDLE,
        RD_BUSY
    } rd_state_t;

    rd_state_t                             rd_state;
    logic [pt_walk_pkg::WB_ADR_WIDTH-1:0]  adr_q;

    // Pull page field and status bits out of a raw entry
    function automatic pt_walk_pkg::pte_t pte_decode(
        input logic [pt_walk_pkg::PTE_WIDTH-1:0] w
    );
        pt_walk_pkg::pte_t p;
        p.page            = w[pt_walk_pkg::PAGE_OFFSET_BITS +: pt_walk_pkg::PA_PAGE_WIDTH];
        p.status.error    = w[pt_walk_pkg::PTE_ERROR_BIT];
        p.status.terminal = w[pt_walk_pkg::PTE_TERMINAL_BIT];
        return p;
    endfunction

    // ========================================
    // Bus cycle FSM
    // ========================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_state  <= RD_IDLE;
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= 1'b0;
            case (rd_state)
                RD_IDLE:
                begin
                    if (rd_start)
                    begin
                        rd_state <= RD_BUSY;
                    end
                end
                default:
                begin
                    // Drop the strobe right after ack
                    if (wb_s.ack)
                    begin
                        rd_state  <= RD_IDLE;
                        rsp_valid <= 1'b1;
                    end
                end
            endcase
        end
    end

    // Address and response payload
    always_ff @(posedge clk)
    begin
        if ((rd_state == RD_IDLE) && rd_start)
        begin
            adr_q <= rd_adr;
        end
        if ((rd_state == RD_BUSY) && wb_s.ack)
        begin
            rsp_pte <= pte_decode(wb_s.dat);
        end
    end

    // Address held stable for the whole cycle
    always_comb
    begin
        wb_m.cyc = (rd_state == RD_BUSY);
        wb_m.stb = (rd_state == RD_BUSY);
        wb_m.adr = adr_q;
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the page table walker testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_pt_walk || exit 1

./obj_dir/Vtb_pt_walk > sim.log 2>&1
cat sim.log

grep -qx "Simulation passed" sim.log && echo "run_sim: PASS" || { echo "run_sim: FAIL"; exit 1; }

// File: sources.f
hdl/pt_walk_pkg.sv
hdl/pt_walk_ctrl.sv
hdl/pt_wb_reader.sv
hdl/pt_walk_top.sv
testbench/pt_walk_checker.sv
testbench/tb_pt_walk.sv

// File: testbench/pt_walk_checker.sv
// Walk checker with reference walk function, result comparison, per-test lines and closing counts
`timescale 1ns/100ps
`default_nettype none

module pt_walk_checker
(
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire pt_walk_pkg::pt_cfg_t       cfg,
    input  wire pt_walk_pkg::walk_req_t     req,
    input  wire logic                       req_valid,
    input  wire logic                       req_ready,
    input  wire pt_walk_pkg::tlb_fill_t     fill,
    input  wire logic                       fill_valid,
    input  wire logic                       fill_ready,
    input  wire logic                       not_present,
    input  wire pt_walk_pkg::wb_master_t    wb_m,
    input  wire logic                       report,
    output int                              tests_done,
    output int                              error_count
);

    // Longest a single walk may stay open
    localparam int WALK_LIMIT = 4 * 12 + 20;

    typedef struct packed {
        logic                   present;
        pt_walk_pkg::tlb_fill_t fill;
    } expect_t;

    expect_t                exp_q;
    logic                   pending;
    logic                   test_ok;
    int                     pend_cycles;
    int                     test_id;
    int                     tests_passed;
    int                     tests_failed;
    logic                   enable_q;
    logic                   gate_done;
    logic                   gate_ok = 1'b1;
    logic                   held;
    pt_walk_pkg::tlb_fill_t held_fill;
    logic                   reported;

    // ========================================
    // Reference walk
    // ========================================

    // Four levels of 9 index bits with the page field in entry bits 39..12
    function automatic expect_t ref_walk(input logic [35:0] va, input logic [27:0] root);
        expect_t     e;
        logic [27:0] page;
        logic [36:0] adr;
        logic [63:0] w;
        int          d;
        e.present = 1'b0;
        e.fill.va_page = va;
        e.fill.pa_page = '0;
        e.fill.big_page = 1'b0;
        page = root;
        for (d = 0; d < 4; d++)
        begin
            adr = {page, va[35 - 9 * d -: 9]};
            if (tb_pt_walk.pt_mem.exists(adr))
                w = tb_pt_walk.pt_mem[adr];
            else
                w = '1;
            // Error bit set or entry absent
            if (w[1])
                return e;
            if (w[0])
            begin
                // Terminal only legal at 2 MB or 4 KB level
                if (d >= 2)
                begin
                    e.present = 1'b1;
                    e.fill.pa_page = w[39:12];
                    e.fill.big_page = (d == 2);
                end
                return e;
            end
            page = w[39:12];
        end
        // Pointer at the leaf level
        return e;
    endfunction

    function automatic string describe(input expect_t e);
        if (!e.present)
            return "not present";
        return $sformatf("va %h pa %h %s", e.fill.va_page, e.fill.pa_page,
                         e.fill.big_page ? "2MB" : "4KB");
    endfunction

    task automatic finish_test(input logic got_present, input pt_walk_pkg::tlb_fill_t got);
        logic ok;
        ok = test_ok && (got_present == exp_q.present);
        if (ok && got_present)
            ok = (got == exp_q.fill);
        tests_done++;
        if (ok)
        begin
            tests_passed++;
            $display("PASS test %0d: %s", test_id, describe(exp_q));
        end
        else
        begin
            tests_failed++;
            error_count++;
            $display("FAIL %0t: test %0d expected %s, got %s", $time, test_id,
                     describe(exp_q), describe(expect_t'({got_present, got})));
        end
    endtask

    // ========================================
    // Compare process
    // ========================================

    always @(posedge clk)
    begin
        if (reset)
        begin
            pending = 1'b0;
            enable_q = 1'b0;
            gate_done = 1'b0;
            held = 1'b0;
            reported = 1'b0;
        end
        else
        begin
            // Nothing may move before the enable is registered
            if (!enable_q && (req_ready || fill_valid || not_present || wb_m.cyc))
            begin
                $display("FAIL %0t: walker active before enable", $time);
                error_count++;
                gate_ok = 1'b0;
            end
            if (enable_q && !gate_done)
            begin
                gate_done = 1'b1;
                if (gate_ok)
                    $display("PASS gate: no activity before enable");
                else
                    $display("FAIL %0t: gate test failed", $time);
            end
            enable_q = cfg.enable;

            // Stalled fill must hold
            if (held && (!fill_valid || (fill != held_fill)))
            begin
                $display("FAIL %0t: fill changed while stalled", $time);
                error_count++;
                test_ok = 1'b0;
            end
            held = fill_valid && !fill_ready;
            held_fill = fill;

            if (fill_valid && not_present)
            begin
                $display("FAIL %0t: fill_valid and not_present both high", $time);
                error_count++;
                test_ok = 1'b0;
            end

            if (pending)
            begin
                pend_cycles++;
                if (pend_cycles > WALK_LIMIT)
                begin
                    $display("Walk for test %0d did not finish within %0d cycles",
                             test_id, WALK_LIMIT);
                    error_count++;
                    tests_failed++;
                    tests_done++;
                    pending = 1'b0;
                end
                else if (req_ready)
                begin
                    $display("FAIL %0t: req_ready high during test %0d", $time, test_id);
                    error_count++;
                    test_ok = 1'b0;
                end
            end

            if ((fill_valid || not_present) && !pending)
            begin
                $display("Result seen at time %0t with no request pending", $time);
                error_count++;
            end
            else if (not_present)
            begin
                finish_test(1'b0, fill);
                pending = 1'b0;
            end
            else if (fill_valid && fill_ready)
            begin
                finish_test(1'b1, fill);
                pending = 1'b0;
            end

            // Accepted request
            if (req_valid && req_ready)
            begin
                exp_q = ref_walk(req.va_page, cfg.root);
                pending = 1'b1;
                pend_cycles = 0;
                test_ok = 1'b1;
                test_id++;
            end

            if (report && !reported)
            begin
                reported = 1'b1;
                $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                         tests_done, tests_passed, tests_failed, error_count);
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_pt_walk.sv
// Testbench top with clock, reset, LCG stimulus, page table memory as Wishbone slave and watchdog
`timescale 1ns/100ps
`default_nettype none

module tb_pt_walk;

    // ========================================
    // Run constants
    // ========================================

    localparam int          NUM_REQ     = 48;
    localparam logic [31:0] SEED        = 32'h356d834d;
    localparam logic [27:0] ROOT_PAGE   = 28'h0100000;
    // Worst case per walk is four levels of about 12 cycles plus fill stalls
    localparam int          WATCHDOG_NS = NUM_REQ * (4 * 12 + 20) * 10 + 1000;

    logic                    clk = 1'b0;
    logic                    reset;
    pt_walk_pkg::pt_cfg_t    cfg;
    pt_walk_pkg::walk_req_t  req;
    logic                    req_valid;
    logic                    req_ready;
    pt_walk_pkg::tlb_fill_t  fill;
    logic                    fill_valid;
    logic                    fill_ready;
    logic                    not_present;
    pt_walk_pkg::wb_master_t wb_m;
    pt_walk_pkg::wb_slave_t  wb_s;
    logic                    report;
    int                      tests_done;
    int                      error_count;

    // Sparse page table, keyed by entry word address
    logic [63:0] pt_mem [logic [36:0]];
    logic [35:0] va_list [NUM_REQ];
    logic [27:0] next_page;

    // Separate generator state per process
    logic [31:0] build_rng = SEED;
    logic [31:0] req_rng   = SEED ^ 32'h0000_5a5a;
    logic [31:0] bus_rng   = SEED ^ 32'h9e37_79b9;
    logic [31:0] stall_rng = SEED ^ 32'h7f4a_7c15;

    logic        bus_busy;
    int          wait_left;
    int          stall_left;

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // ========================================
    // Page table construction
    // ========================================

    // Kinds 0 to 2 end at a depth-3 leaf and kinds 3 and 4 at a depth-2 leaf
    // Kind 5 hits an error bit, kind 6 an absent entry, kind 7 a leaf at depth 1
    task automatic build_table();
        int          n;
        int          d;
        int          kind;
        int          stop;
        logic [27:0] page;
        logic [35:0] va;
        logic [63:0] w;
        logic [36:0] adr;
        next_page = ROOT_PAGE + 28'd1;
        for (n = 0; n < NUM_REQ; n++)
        begin
            build_rng = lcg_step(build_rng);
            kind = int'(build_rng[18:16]);
            build_rng = lcg_step(build_rng);
            // Top index is unique per walk so paths never collide
            va = {9'(n), build_rng[31:5]};
            va_list[n] = va;
            case (kind)
                0, 1, 2: stop = 3;
                3, 4:    stop = 2;
                7:       stop = 1;
                default: stop = int'(build_rng[4:3]);
            endcase
            page = ROOT_PAGE;
            for (d = 0; d <= stop; d++)
            begin
                adr = {page, va[35 - 9 * d -: 9]};
                build_rng = lcg_step(build_rng);
                w[63:32] = build_rng;
                build_rng = lcg_step(build_rng);
                w[31:0] = build_rng;
                if (d < stop)
                begin
                    // Pointer to a fresh table page with junk in the unused bits
                    w[39:12] = next_page;
                    w[1:0] = 2'b00;
                    pt_mem[adr] = w;
                    page = next_page;
                    next_page = next_page + 28'd1;
                end
                else if (kind == 5)
                begin
                    w[1] = 1'b1;
                    pt_mem[adr] = w;
                end
                else if (kind != 6)
                begin
                    // Terminal entry with a random physical page
                    w[1:0] = 2'b01;
                    pt_mem[adr] = w;
                end
            end
        end
    endtask

    // ========================================
    // DUT and checker
    // ========================================

    pt_walk_top pt_walk_top_i
    (
        .clk         (clk),
        .reset       (reset),
        .cfg         (cfg),
        .req         (req),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .fill        (fill),
        .fill_valid  (fill_valid),
        .fill_ready  (fill_ready),
        .not_present (not_present),
        .wb_m        (wb_m),
        .wb_s        (wb_s)
    );

    pt_walk_checker pt_walk_checker_i
    (
        .clk         (clk),
        .reset       (reset),
        .cfg         (cfg),
        .req         (req),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .fill        (fill),
        .fill_valid  (fill_valid),
        .fill_ready  (fill_ready),
        .not_present (not_present),
        .wb_m        (wb_m),
        .report      (report),
        .tests_done  (tests_done),
        .error_count (error_count)
    );

    // ========================================
    // Wishbone slave model
    // ========================================

    initial
    begin
        wb_s = '0;
        bus_busy = 1'b0;
        wait_left = 0;
        forever
        begin
            @(negedge clk);
            if (wb_s.ack)
            begin
                // Single-cycle ack
                wb_s.ack = 1'b0;
                bus_busy = 1'b0;
            end
            else if (wb_m.cyc && wb_m.stb)
            begin
                if (!bus_busy)
                begin
                    bus_busy = 1'b1;
                    bus_rng = lcg_step(bus_rng);
                    wait_left = int'(bus_rng[18:16]);
                end
                if (wait_left == 0)
                begin
                    wb_s.ack = 1'b1;
                    // Unmapped words read as all ones
                    wb_s.dat = pt_mem.exists(wb_m.adr) ? pt_mem[wb_m.adr] : '1;
                end
                else
                begin
                    wait_left--;
                end
            end
        end
    end

    // Fill back-pressure in random stretches of up to 16 cycles
    initial
    begin
        fill_ready = 1'b0;
        stall_left = 0;
        forever
        begin
            @(negedge clk);
            if (stall_left > 0)
            begin
                fill_ready = 1'b0;
                stall_left--;
            end
            else
            begin
                stall_rng = lcg_step(stall_rng);
                fill_ready = (stall_rng[31:30] != 2'b00);
                stall_left = fill_ready ? 0 : int'(stall_rng[19:16]);
            end
        end
    end

    // ========================================
    // Request stimulus
    // ========================================

    initial
    begin
        int n;
        reset = 1'b1;
        cfg = '0;
        req = '0;
        req_valid = 1'b0;
        report = 1'b0;
        build_table();
        cfg.root = ROOT_PAGE;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        // Offered while disabled, must not be taken
        req.va_page = va_list[0];
        req_valid = 1'b1;
        repeat (20) @(negedge clk);
        req_valid = 1'b0;
        cfg.enable = 1'b1;

        for (n = 0; n < NUM_REQ; n++)
        begin
            req_rng = lcg_step(req_rng);
            repeat (int'(req_rng[17:16])) @(negedge clk);
            req.va_page = va_list[n];
            req_valid = 1'b1;
            // req_ready seen here holds through the next rising edge
            while (!req_ready)
            begin
                @(negedge clk);
            end
            @(negedge clk);
            req_valid = 1'b0;
        end

        while (tests_done < NUM_REQ)
        begin
            @(negedge clk);
        end
        // Catch stray pulses after the last walk
        repeat (5) @(negedge clk);
        report = 1'b1;
        @(posedge clk);
        #1;
        if ((error_count == 0) && (tests_done == NUM_REQ))
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog
    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with %0d of %0d walks finished",
                 WATCHDOG_NS, tests_done, NUM_REQ);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
